// File: pkgTpu.sv
/*
 * Shared definitions of the scalar execution lane
 * Operand words, issue tags, commands, memory requests and opcode helpers
 */
package pkgTpu;

	////////////////////////////////////////////////////////////////////////////
	// Basic words
	typedef logic [31:0]	dataT;				// Operand and result word
	typedef logic [7:0]		issueNoT;			// Issue number, wraps at 256
	typedef logic [3:0]		regIdxT;			// Register index

	typedef enum logic [3:0] {
		opAdd		= 4'h0,
		opSub		= 4'h1,
		opAnd		= 4'h2,
		opOr		= 4'h3,
		opXor		= 4'h4,
		opShl		= 4'h5,
		opMov		= 4'h6,						// Copy of src1
		opMovHi		= 4'h7,						// Constant 32'h78000000
		opMovZero	= 4'h8,						// Constant zero
		opLoad		= 4'h9,
		opStore		= 4'hA
	} opT;

	////////////////////////////////////////////////////////////////////////////
	// Bundles
	typedef struct packed {
		logic			valid;
		opT				op;
		regIdxT			dst;
		regIdxT			src1;
		regIdxT			src2;
		logic			useImm;					// Immediate replaces src2
		logic			ldStPort;				// High selects the odd unit
		logic [15:0]	imm;					// Sign-extended on use
	} exeCmdT;

	typedef struct packed {
		issueNoT		issueNo;
		regIdxT			dst;
	} wbTokenT;

	typedef struct packed {
		logic			valid;
		logic			write;					// Store when high
		dataT			address;
	} ldStCmdT;

	typedef struct packed {
		exeCmdT			cmd;
		wbTokenT		token;
		dataT			data1;
		dataT			data2;
	} pipeExeT;

	////////////////////////////////////////////////////////////////////////////
	// Constants and helpers
	localparam dataT	movHiConst	= 32'h78000000;
	localparam issueNoT	noAge		= '0;		// Age of a source with no result

	// Larger value means an older result
	function automatic issueNoT ageOf(issueNoT current, issueNoT tag);
		return issueNoT'(current - tag);
	endfunction

	function automatic logic isAluOp(opT op);
		return op inside {opAdd, opSub, opAnd, opOr, opXor, opShl};
	endfunction

	function automatic logic isMoveOp(opT op);
		return op inside {opMov, opMovHi, opMovZero};
	endfunction

	function automatic logic isLdStOp(opT op);
		return op inside {opLoad, opStore};
	endfunction

	function automatic dataT sextImm(logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

endpackage

// File: RingBuff.sv
/*
 * RingBuff
 * Circular buffer with a type-parameterised entry, head visible on q
 */
`timescale 1ns/10ps

module RingBuff #(
	parameter int	numEntry	= 8,
	parameter type	TYPE		= logic [31:0]
)(
	input	logic		clock,
	input	logic		reset,
	input	logic		we,
	input	logic		re,
	input	TYPE		data,
	output	TYPE		q,
	output	logic		full,
	output	logic		empty
);

	localparam int ptrW = (numEntry > 1) ? $clog2(numEntry) : 1;
	localparam int cntW = $clog2(numEntry + 1);

	TYPE				mem [numEntry];
	logic [ptrW-1:0]	wrPtr;
	logic [ptrW-1:0]	rdPtr;
	logic [cntW-1:0]	count;
	logic				doWrite;
	logic				doRead;

	assign full		= (count == cntW'(numEntry));
	assign empty	= (count == '0);
	assign doWrite	= we & ~full;
	assign doRead	= re & ~empty;
	assign q		= mem[rdPtr];					// No read latency

	always_ff @(posedge clock) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doWrite)
				wrPtr <= (wrPtr == ptrW'(numEntry - 1)) ? '0 : wrPtr + 1'b1;
			if (doRead)
				rdPtr <= (rdPtr == ptrW'(numEntry - 1)) ? '0 : rdPtr + 1'b1;
			if (doWrite & ~doRead)
				count <= count + 1'b1;
			else if (doRead & ~doWrite)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (doWrite)
			mem[wrPtr] <= data;
	end

endmodule

// File: ALU.sv
/*
 * ALU
 * Two-stage integer pipeline, the output stage holds until taken
 */
`timescale 1ns/10ps

module ALU (
	input	logic				clock,
	input	logic				reset,
	input	logic				req,
	input	logic				take,
	input	pkgTpu::exeCmdT		cmd,
	input	pkgTpu::wbTokenT	token,
	input	pkgTpu::dataT		data1,
	input	pkgTpu::dataT		data2,
	output	logic				ready,
	output	logic				stall,
	output	pkgTpu::wbTokenT	resToken,
	output	pkgTpu::dataT		resData
);

	import pkgTpu::*;

	logic		s1Valid;
	logic		s2Valid;
	opT			s1Op;
	wbTokenT	s1Token;
	dataT		s1A;
	dataT		s1B;
	dataT		aluOut;
	logic		advance;

	assign advance	= s1Valid & (~s2Valid | take);	// Stage 1 moves on
	assign ready	= s2Valid;
	assign stall	= s1Valid & s2Valid & ~take;

	always_comb begin
		case (s1Op)
			opAdd:		aluOut = s1A + s1B;
			opSub:		aluOut = s1A - s1B;
			opAnd:		aluOut = s1A & s1B;
			opOr:		aluOut = s1A | s1B;
			opXor:		aluOut = s1A ^ s1B;
			opShl:		aluOut = s1A << s1B[4:0];
			default:	aluOut = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
		end else begin
			if (req)
				s1Valid <= 1'b1;
			else if (advance)
				s1Valid <= 1'b0;
			if (advance)
				s2Valid <= 1'b1;
			else if (take)
				s2Valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (req) begin
			s1Op	<= cmd.op;
			s1Token	<= token;
			s1A		<= data1;
			s1B		<= data2;						// Immediate already merged
		end
		if (advance) begin
			resToken	<= s1Token;
			resData		<= aluOut;
		end
	end

endmodule

// File: LdStUnit.sv
/*
 * LdStUnit
 * Runs one load or store on a memory port and holds the loaded word
 */
`timescale 1ns/10ps

module LdStUnit (
	input	logic				clock,
	input	logic				reset,
	input	logic				req,
	input	logic				take,
	input	pkgTpu::exeCmdT		cmd,
	input	pkgTpu::wbTokenT	token,
	input	pkgTpu::dataT		data1,
	input	pkgTpu::dataT		data2,
	output	pkgTpu::ldStCmdT	ldSt,
	output	pkgTpu::dataT		stData,
	input	pkgTpu::dataT		ldData,
	input	logic				grant,
	input	logic				endAccess,
	output	logic				idle,
	output	logic				ready,
	output	pkgTpu::wbTokenT	resToken,
	output	pkgTpu::dataT		resData
);

	import pkgTpu::*;

	typedef enum logic [1:0] {
		stIdle,
		stRequest,
		stAccess,
		stResult
	} stateT;

	stateT		state;
	logic		isWrite;
	dataT		address;
	logic		accept;

	assign accept	= req & (state == stIdle);
	assign idle		= (state == stIdle);
	assign ready	= (state == stResult);

	assign ldSt = '{
		valid:		(state == stRequest),			// Held until grant
		write:		isWrite,
		address:	address
	};

	////////////////////////////////////////////////////////////////////////////
	// Sequencer
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= stIdle;
		end else begin
			case (state)
				stIdle:		if (req)		state <= stRequest;
				stRequest:	if (grant)		state <= stAccess;
				stAccess:	if (endAccess)	state <= isWrite ? stIdle : stResult;
				stResult:	if (take)		state <= stIdle;
				default:					state <= stIdle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Request and result payload
	always_ff @(posedge clock) begin
		if (accept) begin
			isWrite		<= (cmd.op == opStore);
			address		<= data1 + sextImm(cmd.imm);
			stData		<= data2;
			resToken	<= token;
		end
		if ((state == stAccess) & endAccess & ~isWrite)
			resData <= ldData;						// Sampled at end of access
	end

endmodule

// File: ExecUnit_S.sv
/*
 * ExecUnit_S
 * Splits commands over the ALU, move queue and two load/store units,
 * then writes back the oldest ready result each cycle
 */
`timescale 1ns/10ps

module ExecUnit_S #(
	parameter int moveDepth = 8
)(
	input	logic				clock,
	input	logic				reset,
	input	pkgTpu::pipeExeT	command,
	output	pkgTpu::ldStCmdT	ldSt0,
	output	pkgTpu::ldStCmdT	ldSt1,
	output	pkgTpu::dataT		stData0,
	output	pkgTpu::dataT		stData1,
	input	pkgTpu::dataT		ldData0,
	input	pkgTpu::dataT		ldData1,
	input	logic [1:0]			ldGrant,
	input	logic [1:0]			endAccess,
	output	logic				busy,
	input	pkgTpu::issueNoT	issueNo,
	output	logic				wbValid,
	output	pkgTpu::wbTokenT	wbToken,
	output	pkgTpu::dataT		wbData
);

	import pkgTpu::*;

	localparam int srcAlu	= 0;
	localparam int srcMove	= 1;
	localparam int srcLd0	= 2;
	localparam int srcLd1	= 3;
	localparam int numSrc	= 4;

	exeCmdT					cmd;
	logic					aluReq;
	logic					moveReq;
	logic [1:0]				ldStReq;
	dataT					moveData;
	logic					aluStall;
	logic					tokFull;
	logic					tokEmpty;
	logic					datFull;
	logic					datEmpty;
	logic [1:0]				ldStIdle;
	logic [numSrc-1:0]		srcReady;
	logic [numSrc-1:0]		take;
	wbTokenT				srcToken [numSrc];
	dataT					srcData [numSrc];
	issueNoT				srcAge [numSrc];
	issueNoT				bestAge;
	logic [1:0]				sel;

	////////////////////////////////////////////////////////////////////////////
	// Decode
	assign cmd			= command.cmd;
	assign aluReq		= cmd.valid & isAluOp(cmd.op);
	assign moveReq		= cmd.valid & isMoveOp(cmd.op);
	assign ldStReq[0]	= cmd.valid & isLdStOp(cmd.op) & ~cmd.ldStPort;	// Even port
	assign ldStReq[1]	= cmd.valid & isLdStOp(cmd.op) & cmd.ldStPort;		// Odd port

	assign moveData		= (cmd.op == opMovHi)	? movHiConst :
							(cmd.op == opMovZero)	? '0 :
													command.data1;

	assign srcReady[srcMove]	= ~tokEmpty & ~datEmpty;
	assign busy					= ~&ldStIdle | tokFull | datFull | aluStall;

	////////////////////////////////////////////////////////////////////////////
	// Oldest-first write-back select
	always_comb begin
		bestAge	= noAge;
		sel		= '0;
		for (int i = 0; i < numSrc; i++) begin
			srcAge[i] = srcReady[i] ? ageOf(issueNo, srcToken[i].issueNo) : noAge;
			if (srcAge[i] > bestAge) begin
				bestAge	= srcAge[i];
				sel		= 2'(i);
			end
		end
	end

	assign wbValid	= (bestAge != noAge);
	assign take		= numSrc'(wbValid) << sel;	// One strobe per cycle
	assign wbToken	= srcToken[sel];
	assign wbData	= srcData[sel];

	ALU u_ALU (
		.clock(clock),			.reset(reset),
		.req(aluReq),			.take(take[srcAlu]),
		.cmd(cmd),				.token(command.token),
		.data1(command.data1),	.data2(command.data2),
		.ready(srcReady[srcAlu]),	.stall(aluStall),
		.resToken(srcToken[srcAlu]),	.resData(srcData[srcAlu])
	);

	LdStUnit u_LdStEven (
		.clock(clock),			.reset(reset),
		.req(ldStReq[0]),		.take(take[srcLd0]),
		.cmd(cmd),				.token(command.token),
		.data1(command.data1),	.data2(command.data2),
		.ldSt(ldSt0),			.stData(stData0),		.ldData(ldData0),
		.grant(ldGrant[0]),		.endAccess(endAccess[0]),
		.idle(ldStIdle[0]),		.ready(srcReady[srcLd0]),
		.resToken(srcToken[srcLd0]),	.resData(srcData[srcLd0])
	);

	LdStUnit u_LdStOdd (
		.clock(clock),			.reset(reset),
		.req(ldStReq[1]),		.take(take[srcLd1]),
		.cmd(cmd),				.token(command.token),
		.data1(command.data1),	.data2(command.data2),
		.ldSt(ldSt1),			.stData(stData1),		.ldData(ldData1),
		.grant(ldGrant[1]),		.endAccess(endAccess[1]),
		.idle(ldStIdle[1]),		.ready(srcReady[srcLd1]),
		.resToken(srcToken[srcLd1]),	.resData(srcData[srcLd1])
	);

	RingBuff #(.numEntry(moveDepth), .TYPE(wbTokenT)) u_MoveTokenBuff (
		.clock(clock),	.reset(reset),
		.we(moveReq),	.re(take[srcMove]),
		.data(command.token),	.q(srcToken[srcMove]),
		.full(tokFull),	.empty(tokEmpty)
	);

	RingBuff #(.numEntry(moveDepth), .TYPE(dataT)) u_MoveDataBuff (
		.clock(clock),	.reset(reset),
		.we(moveReq),	.re(take[srcMove]),
		.data(moveData),	.q(srcData[srcMove]),
		.full(datFull),	.empty(datEmpty)
	);

endmodule

// File: RegFile.sv
/*
 * RegFile
 * Sixteen 32-bit registers, two asynchronous reads and one write
 */
`timescale 1ns/10ps

module RegFile (
	input	logic				clock,
	input	logic				reset,
	input	logic				we,
	input	pkgTpu::regIdxT		wAddr,
	input	pkgTpu::regIdxT		rAddr1,
	input	pkgTpu::regIdxT		rAddr2,
	input	pkgTpu::dataT		wData,
	output	pkgTpu::dataT		rData1,
	output	pkgTpu::dataT		rData2
);

	import pkgTpu::*;

	dataT	regs [16];

	assign rData1 = regs[rAddr1];
	assign rData2 = regs[rAddr2];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wAddr] <= wData;					// Visible after the edge
		end
	end

endmodule

// File: ScalarLane.sv
/*
 * ScalarLane
 * Scalar execution lane with issue counter, operand read and write-back
 */
`timescale 1ns/10ps

module ScalarLane #(
	parameter int moveDepth = 8
)(
	input	logic				clock,
	input	logic				reset,
	input	pkgTpu::exeCmdT		cmd,
	output	logic				busy,
	output	pkgTpu::ldStCmdT	ldSt0,
	output	pkgTpu::ldStCmdT	ldSt1,
	output	pkgTpu::dataT		stData0,
	output	pkgTpu::dataT		stData1,
	input	pkgTpu::dataT		ldData0,
	input	pkgTpu::dataT		ldData1,
	input	logic [1:0]			ldGrant,
	input	logic [1:0]			endAccess,
	output	logic				wbValid,
	output	pkgTpu::wbTokenT	wbToken,
	output	pkgTpu::dataT		wbData
);

	import pkgTpu::*;

	issueNoT	issueCnt;
	dataT		rData1;
	dataT		rData2;
	pipeExeT	command;

	always_ff @(posedge clock) begin
		if (reset)
			issueCnt <= '0;
		else if (cmd.valid)
			issueCnt <= issueCnt + 1'b1;			// Next tag to hand out
	end

	always_comb begin
		command.cmd				= cmd;
		command.token.issueNo	= issueCnt;
		command.token.dst		= cmd.dst;
		command.data1			= rData1;
		command.data2			= (cmd.useImm & isAluOp(cmd.op)) ? sextImm(cmd.imm) : rData2;
	end

	RegFile u_RegFile (
		.clock(clock),		.reset(reset),
		.we(wbValid),		.wAddr(wbToken.dst),	.wData(wbData),
		.rAddr1(cmd.src1),	.rAddr2(cmd.src2),
		.rData1(rData1),	.rData2(rData2)
	);

	ExecUnit_S #(.moveDepth(moveDepth)) u_ExecUnit (
		.clock(clock),			.reset(reset),
		.command(command),		.issueNo(issueCnt),
		.ldSt0(ldSt0),			.ldSt1(ldSt1),
		.stData0(stData0),		.stData1(stData1),
		.ldData0(ldData0),		.ldData1(ldData1),
		.ldGrant(ldGrant),		.endAccess(endAccess),
		.busy(busy),
		.wbValid(wbValid),		.wbToken(wbToken),		.wbData(wbData)
	);

endmodule

// File: tbScalarLane.sv
/*
 * tbScalarLane
 * Testbench for the scalar lane with a two-port memory model,
 * a stimulus table, a write-back scoreboard and age-order checks
 */
`timescale 1ns/10ps

module tbScalarLane;

	import pkgTpu::*;

	localparam int period		= 10;
	localparam int resetCycles	= 16;
	localparam int numRows		= 40;

	typedef struct packed {
		opT				op;
		regIdxT			dst;
		regIdxT			src1;
		regIdxT			src2;
		logic			useImm;
		logic [15:0]	imm;
		logic			port;
	} rowT;

	// op, dst, src1, src2, useImm, imm, port
	localparam rowT stim [numRows] = '{
		'{opAdd,     4'd1,  4'd0,  4'd0, 1'b1, 16'h1234, 1'b0},
		'{opAdd,     4'd2,  4'd0,  4'd0, 1'b1, 16'hFFF0, 1'b0},	// Negative immediate
		'{opOr,      4'd3,  4'd0,  4'd0, 1'b1, 16'h0005, 1'b0},
		'{opAdd,     4'd4,  4'd1,  4'd2, 1'b0, 16'h0000, 1'b0},
		'{opSub,     4'd5,  4'd1,  4'd2, 1'b0, 16'h0000, 1'b0},
		'{opAnd,     4'd6,  4'd1,  4'd2, 1'b0, 16'h0000, 1'b0},
		'{opOr,      4'd7,  4'd1,  4'd2, 1'b0, 16'h0000, 1'b0},
		'{opXor,     4'd8,  4'd1,  4'd2, 1'b0, 16'h0000, 1'b0},
		'{opShl,     4'd9,  4'd1,  4'd0, 1'b1, 16'h0004, 1'b0},
		'{opShl,     4'd10, 4'd1,  4'd3, 1'b0, 16'h0000, 1'b0},
		'{opSub,     4'd11, 4'd1,  4'd0, 1'b1, 16'h0034, 1'b0},
		'{opXor,     4'd12, 4'd2,  4'd0, 1'b1, 16'h00FF, 1'b0},
		'{opAnd,     4'd13, 4'd2,  4'd0, 1'b1, 16'h0F0F, 1'b0},
		'{opMov,     4'd14, 4'd1,  4'd0, 1'b0, 16'h0000, 1'b0},
		'{opMovHi,   4'd15, 4'd0,  4'd0, 1'b0, 16'h0000, 1'b0},
		'{opMovZero, 4'd9,  4'd0,  4'd0, 1'b0, 16'h0000, 1'b0},
		'{opStore,   4'd0,  4'd3,  4'd1, 1'b0, 16'h0002, 1'b0},	// Even port
		'{opStore,   4'd0,  4'd3,  4'd4, 1'b0, 16'h0003, 1'b1},	// Odd port
		'{opLoad,    4'd10, 4'd3,  4'd0, 1'b0, 16'h0002, 1'b0},
		'{opLoad,    4'd11, 4'd3,  4'd0, 1'b0, 16'h0003, 1'b1},
		'{opLoad,    4'd12, 4'd0,  4'd0, 1'b0, 16'h0014, 1'b0},
		'{opLoad,    4'd13, 4'd0,  4'd0, 1'b0, 16'h0009, 1'b1},
		'{opMov,     4'd5,  4'd7,  4'd0, 1'b0, 16'h0000, 1'b0},
		'{opAdd,     4'd6,  4'd8,  4'd1, 1'b0, 16'h0000, 1'b0},
		'{opMovHi,   4'd7,  4'd0,  4'd0, 1'b0, 16'h0000, 1'b0},
		'{opLoad,    4'd8,  4'd0,  4'd0, 1'b0, 16'h0007, 1'b0},
		'{opXor,     4'd13, 4'd5,  4'd6, 1'b0, 16'h0000, 1'b0},
		'{opStore,   4'd0,  4'd0,  4'd13, 1'b0, 16'h001E, 1'b1},
		'{opLoad,    4'd14, 4'd0,  4'd0, 1'b0, 16'h001E, 1'b1},
		'{opShl,     4'd15, 4'd14, 4'd0, 1'b1, 16'h0003, 1'b0},
		'{opMov,     4'd1,  4'd15, 4'd0, 1'b0, 16'h0000, 1'b0},
		'{opSub,     4'd2,  4'd15, 4'd14, 1'b0, 16'h0000, 1'b0},
		'{opMovZero, 4'd3,  4'd0,  4'd0, 1'b0, 16'h0000, 1'b0},
		'{opAdd,     4'd4,  4'd3,  4'd0, 1'b1, 16'h7FFF, 1'b0},
		'{opLoad,    4'd5,  4'd0,  4'd0, 1'b0, 16'hFFFF, 1'b0},	// Address wraps to word 63
		'{opAnd,     4'd6,  4'd5,  4'd2, 1'b0, 16'h0000, 1'b0},
		'{opAdd,     4'd7,  4'd0,  4'd0, 1'b1, 16'h0001, 1'b0},
		'{opMovHi,   4'd8,  4'd0,  4'd0, 1'b0, 16'h0000, 1'b0},
		'{opAdd,     4'd9,  4'd0,  4'd0, 1'b1, 16'h0002, 1'b0},
		'{opMov,     4'd10, 4'd4,  4'd0, 1'b0, 16'h0000, 1'b0}
	};

	logic		clock;
	logic		reset;
	exeCmdT		cmd;
	logic		busy;
	ldStCmdT	ldSt0;
	ldStCmdT	ldSt1;
	dataT		stData0;
	dataT		stData1;
	dataT		ldData0;
	dataT		ldData1;
	logic [1:0]	ldGrant;
	logic [1:0]	endAccess;
	logic		wbValid;
	wbTokenT	wbToken;
	dataT		wbData;

	////////////////////////////////////////////////////////////////////////////
	// Register, memory and scoreboard models
	dataT		regModel [16];
	int			pendingCnt [16];				// Outstanding writes per register
	dataT		memModel [2][64];
	int			memPhase [2];					// 0 idle, 1 before grant, 2 before end
	int			memWait [2];
	ldStCmdT	expReq [2];
	dataT		expStData [2];
	logic		expReqValid [2];
	logic		expValid [256];
	wbTokenT	expTok [256];
	dataT		expData [256];
	int			outstanding;
	issueNoT	tbIssue;
	int			rowIdx;
	logic		retireValid;
	regIdxT		retireDst;

	ScalarLane #(.moveDepth(8)) u_ScalarLane (
		.clock(clock),			.reset(reset),			.cmd(cmd),
		.busy(busy),
		.ldSt0(ldSt0),			.ldSt1(ldSt1),
		.stData0(stData0),		.stData1(stData1),
		.ldData0(ldData0),		.ldData1(ldData1),
		.ldGrant(ldGrant),		.endAccess(endAccess),
		.wbValid(wbValid),		.wbToken(wbToken),		.wbData(wbData)
	);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	task automatic reportFailure();
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	function automatic dataT signExtend(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic dataT aluModel(opT op, dataT a, dataT b);
		case (op)
			opAdd:		return a + b;
			opSub:		return a - b;
			opAnd:		return a & b;
			opOr:		return a | b;
			opXor:		return a ^ b;
			opShl:		return a << b[4:0];
			default:	return '0;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s: got %b expected %b", $time, name, got, exp);
			reportFailure();
		end
	endtask

	task automatic checkWb(wbTokenT got, dataT gotData, wbTokenT exp, dataT expD);
		if (got !== exp) begin
			$display("[FAIL] %0t ns wbToken: got issue %0d dst %0d expected issue %0d dst %0d",
				$time, got.issueNo, got.dst, exp.issueNo, exp.dst);
			reportFailure();
		end
		if (gotData !== expD) begin
			$display("[FAIL] %0t ns wbData: got %h expected %h", $time, gotData, expD);
			reportFailure();
		end
	endtask

	task automatic checkLdSt(int port, ldStCmdT got, dataT gotData, ldStCmdT exp, dataT expD);
		if (got !== exp) begin
			$display("[FAIL] %0t ns ldSt%0d: got %h expected %h", $time, port, got, exp);
			reportFailure();
		end
		if (exp.write && gotData !== expD) begin
			$display("[FAIL] %0t ns stData%0d: got %h expected %h", $time, port, gotData, expD);
			reportFailure();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Per-cycle steps, all run from the falling edge
	task automatic monitorStep();
		issueNoT	tag;
		issueNoT	wbAge;
		issueNoT	age;
		retireValid = 1'b0;
		if (ldSt0.valid || ldSt1.valid || memPhase[0] != 0 || memPhase[1] != 0)
			checkFlag("busy", busy, 1'b1);					// Unit occupied
		if (wbValid) begin
			tag = wbToken.issueNo;
			if (!expValid[tag]) begin
				$display("Write-back at %0t ns for issue %0d has no pending result", $time, tag);
				reportFailure();
			end
			checkWb(wbToken, wbData, expTok[tag], expData[tag]);
			wbAge = tbIssue - tag;
			for (int i = 0; i < 4; i++) begin
				age = tbIssue - u_ScalarLane.u_ExecUnit.srcToken[i].issueNo;
				if (u_ScalarLane.u_ExecUnit.srcReady[i] && age > wbAge) begin
					$display("Write-back of issue %0d at %0t ns passed an older ready result",
						tag, $time);
					reportFailure();
				end
			end
			expValid[tag] = 1'b0;
			outstanding--;
			regModel[expTok[tag].dst] = expData[tag];
			retireValid = 1'b1;
			retireDst = expTok[tag].dst;
		end
	endtask

	task automatic memoryStep();
		ldStCmdT	req;
		dataT		sd;
		logic [5:0]	idx;
		ldGrant = '0;
		endAccess = '0;
		for (int p = 0; p < 2; p++) begin
			req = (p == 0) ? ldSt0 : ldSt1;
			sd = (p == 0) ? stData0 : stData1;
			if (memPhase[p] == 0 && expReqValid[p])
				checkFlag($sformatf("ldSt%0d.valid", p), req.valid, 1'b1);	// Cycle after issue
			if (memPhase[p] == 0 && req.valid) begin
				if (!expReqValid[p]) begin
					$display("Memory request on port %0d at %0t ns was not expected", p, $time);
					reportFailure();
				end
				checkLdSt(p, req, sd, expReq[p], expStData[p]);
				memWait[p] = int'($urandom % 4);		// Grant delay 0 to 3
				memPhase[p] = 1;
			end
			if (memPhase[p] == 1) begin
				checkFlag($sformatf("ldSt%0d.valid", p), req.valid, 1'b1);
				if (memWait[p] == 0) begin
					ldGrant[p] = 1'b1;
					memWait[p] = int'($urandom % 3);	// End after 1 to 3 more
					memPhase[p] = 2;
				end else begin
					memWait[p]--;
				end
			end else if (memPhase[p] == 2) begin
				checkFlag($sformatf("ldSt%0d.valid", p), req.valid, 1'b0);	// Dropped after grant
				if (memWait[p] == 0) begin
					endAccess[p] = 1'b1;
					idx = expReq[p].address[5:0];
					if (expReq[p].write)
						memModel[p][idx] = expStData[p];
					else if (p == 0)
						ldData0 = memModel[0][idx];
					else
						ldData1 = memModel[1][idx];
					memPhase[p] = 0;
					expReqValid[p] = 1'b0;
				end else begin
					memWait[p]--;
				end
			end
		end
	endtask

	task automatic stimulusStep();
		rowT		row;
		dataT		a;
		dataT		b;
		dataT		addr;
		dataT		res;
		logic		hasResult;
		cmd = '0;
		row = stim[rowIdx < numRows ? rowIdx : 0];
		if (rowIdx < numRows && !busy && pendingCnt[row.src1] == 0 &&
				pendingCnt[row.src2] == 0) begin
			a = regModel[row.src1];
			b = (row.useImm && row.op inside {opAdd, opSub, opAnd, opOr, opXor, opShl}) ?
				signExtend(row.imm) : regModel[row.src2];
			addr = a + signExtend(row.imm);
			hasResult = 1'b1;
			res = '0;
			case (row.op)
				opMov:		res = a;
				opMovHi:	res = 32'h78000000;
				opMovZero:	res = '0;
				opLoad: begin
					expReq[row.port] = '{valid: 1'b1, write: 1'b0, address: addr};
					expReqValid[row.port] = 1'b1;
					res = memModel[row.port][addr[5:0]];
				end
				opStore: begin
					expReq[row.port] = '{valid: 1'b1, write: 1'b1, address: addr};
					expStData[row.port] = regModel[row.src2];
					expReqValid[row.port] = 1'b1;
					hasResult = 1'b0;					// Stores write nothing back
				end
				default:	res = aluModel(row.op, a, b);
			endcase
			if (hasResult) begin
				expValid[tbIssue] = 1'b1;
				expTok[tbIssue] = '{issueNo: tbIssue, dst: row.dst};
				expData[tbIssue] = res;
				outstanding++;
				pendingCnt[row.dst]++;
			end
			cmd = '{valid: 1'b1, op: row.op, dst: row.dst, src1: row.src1, src2: row.src2,
				useImm: row.useImm, ldStPort: row.port, imm: row.imm};
			tbIssue++;
			rowIdx++;
		end
	endtask

	// Register stays blocked until its write has landed
	task automatic stepCycle();
		@(negedge clock);
		monitorStep();
		memoryStep();
		stimulusStep();
		if (retireValid)
			pendingCnt[retireDst]--;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	initial begin
		void'($urandom(57));
		reset = 1'b1;
		cmd = '0;
		ldData0 = '0;
		ldData1 = '0;
		ldGrant = '0;
		endAccess = '0;
		for (int i = 0; i < 16; i++) begin
			regModel[i] = '0;
			pendingCnt[i] = 0;
		end
		for (int i = 0; i < 256; i++)
			expValid[i] = 1'b0;
		for (int p = 0; p < 2; p++) begin
			for (int i = 0; i < 64; i++)
				memModel[p][i] = 32'h5A000000 + 32'(p * 64 + i) * 32'h00010101;
			memPhase[p] = 0;
			memWait[p] = 0;
			expReqValid[p] = 1'b0;
		end
		outstanding = 0;
		tbIssue = '0;
		rowIdx = 0;
		repeat (resetCycles) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		checkFlag("busy", busy, 1'b0);
		checkFlag("wbValid", wbValid, 1'b0);
		checkFlag("ldSt0.valid", ldSt0.valid, 1'b0);
		checkFlag("ldSt1.valid", ldSt1.valid, 1'b0);
		while (rowIdx < numRows)
			stepCycle();
		while (outstanding != 0 || memPhase[0] != 0 || memPhase[1] != 0 || busy)
			stepCycle();
		repeat (10) stepCycle();						// Catch late duplicates
		$display("=== PASS ===");
		$finish;
	end

	initial begin
		repeat (resetCycles + numRows * 40 + 200) @(posedge clock);
		$display("Timeout: the lane did not finish the stimulus table in time");
		reportFailure();
	end

endmodule

// File: filelist.f
pkgTpu.sv
RingBuff.sv
ALU.sv
LdStUnit.sv
ExecUnit_S.sv
RegFile.sv
ScalarLane.sv
tbScalarLane.sv

// File: run.sh
#!/bin/sh
# Build and run the scalar lane testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps --top-module tbScalarLane \
	-f filelist.f -o simScalarLane
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/simScalarLane)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation returned a failing status"
	exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1
